/* capture/capture_writer.sv */
// ==============================
// Capture side of the engine. Pops beats from the ingress FIFO and
// writes each one, packed with its last flag, to the next memory
// address. stored_count doubles as the write pointer.
// ==============================

`timescale 1ns/100ps

module capture_writer #(
  parameter int DATA_WIDTH     = 64,
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clear_capture,
  input  logic                      replay_busy,
  input  logic                      beat_valid,
  output logic                      beat_ready,
  input  logic [DATA_WIDTH-1:0]     beat_data,
  input  logic                      beat_last,
  output logic                      wr_en,
  output logic [MEM_ADDR_WIDTH-1:0] wr_addr,
  output logic [DATA_WIDTH:0]       wr_word,
  output logic [MEM_ADDR_WIDTH:0]   stored_count
);

  logic store_full;

  // Top bit set means every memory word is in use
  assign store_full = stored_count[MEM_ADDR_WIDTH];

  // Hold off during a replay, when full, and while the store is cleared
  assign beat_ready = !replay_busy && !store_full && !clear_capture;

  // Write happens in the same cycle as the pop
  assign wr_en   = beat_valid && beat_ready;
  assign wr_addr = stored_count[MEM_ADDR_WIDTH-1:0];
  assign wr_word = {beat_last, beat_data};

  always_ff @(posedge clk) begin
    if (rst) begin
      stored_count <= '0;
    end else if (clear_capture) begin
      stored_count <= '0;
    end else if (wr_en) begin
      stored_count <= stored_count + 1'b1;
    end
  end

endmodule

/* common/replay_pkg.sv */
// ==============================
// Shared widths, depths and the replay reader state type for the
// packet capture and replay engine. Modules import it where needed.
// ==============================

package replay_pkg;

  // Default stream data width in bits
  localparam int DEFAULT_DATA_WIDTH = 64;

  // Packet memory address width, 256 words by default
  localparam int DEFAULT_MEM_ADDR_WIDTH = 8;

  // Width of replay_count and the pass counter
  localparam int REPLAY_COUNT_WIDTH = 16;

  // Entries per stream FIFO, also the reader credit limit
  localparam int FIFO_DEPTH = 4;

  // Replay reader FSM states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    DRAIN = 2'd2
  } replay_state_t;

endpackage

/* dv/pcap_replay_asserts.sv */
// ==============================
// Concurrent checks on the top level handshakes of the capture
// and replay engine. Bound into pcap_replay_top at the end of
// this file, so the testbench needs no instance of it.
// ==============================

`timescale 1ns/100ps

module pcap_replay_asserts #(
  parameter int DATA_WIDTH = replay_pkg::DEFAULT_DATA_WIDTH
) (
  input logic                  clk,
  input logic                  rst,
  input logic                  s_axis_tready,
  input logic                  m_axis_tvalid,
  input logic                  m_axis_tready,
  input logic [DATA_WIDTH-1:0] m_axis_tdata,
  input logic                  replay_busy
);

  // Stalled output beat keeps valid and data
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata)))
    else $error("m_axis beat changed while stalled");

  // Full ingress FIFO stays full until the replay ends
  ingress_held: assert property (@(posedge clk) disable iff (rst)
    (replay_busy && !s_axis_tready) |=> (!replay_busy || !s_axis_tready))
    else $error("s_axis_tready rose again during a replay");

  // Outputs quiet right after reset
  reset_quiet: assert property (@(posedge clk)
    rst |=> (!m_axis_tvalid && !replay_busy))
    else $error("m_axis_tvalid or replay_busy high after reset");

endmodule

bind pcap_replay_top pcap_replay_asserts #(
  .DATA_WIDTH    (DATA_WIDTH)
) pcap_replay_asserts_inst (
  .clk           (axi_aclk),
  .rst           (rst),
  .s_axis_tready (s_axis_tready),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .replay_busy   (replay_busy)
);

/* dv/pcap_replay_tb.sv */
// ==============================
// Directed testbench for the packet capture and replay engine.
// Sends packets on the slave stream, starts replays and checks the
// master stream against a scoreboard of the captured beats.
// Inputs change on the falling edge, outputs sampled on the rising.
// ==============================

`timescale 1ns/100ps

module pcap_replay_tb;

  import replay_pkg::*;

  localparam int DATA_WIDTH     = DEFAULT_DATA_WIDTH;
  localparam int MEM_ADDR_WIDTH = DEFAULT_MEM_ADDR_WIDTH;
  localparam int MEM_DEPTH      = 2 ** MEM_ADDR_WIDTH;
  localparam int CLK_PERIOD     = 20;
  localparam int MAX_WAIT       = 2000;

  // Beats in and out over all six tests
  localparam int TOTAL_BEATS = 2 * (8 + 24) + 16 + (6 + 32 + 14)
                             + (MEM_DEPTH + FIFO_DEPTH + 1) + MEM_DEPTH + (2 + 4);

  logic                          axi_aclk;
  logic                          rst;
  logic [DATA_WIDTH-1:0]         s_axis_tdata;
  logic                          s_axis_tvalid;
  logic                          s_axis_tready;
  logic                          s_axis_tlast;
  logic [DATA_WIDTH-1:0]         m_axis_tdata;
  logic                          m_axis_tvalid;
  logic                          m_axis_tready;
  logic                          m_axis_tlast;
  logic                          start_replay;
  logic [REPLAY_COUNT_WIDTH-1:0] replay_count;
  logic                          clear_capture;
  logic                          replay_busy;

  // Beats kept as {last, data}
  logic [DATA_WIDTH:0] exp_q [$];
  logic [DATA_WIDTH:0] captured [$];
  logic [DATA_WIDTH:0] pending [$];

  integer seed;
  int     errors;
  bit     random_ready;

  pcap_replay_top #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) pcap_replay_top_inst (
    .axi_aclk       (axi_aclk),
    .rst            (rst),
    .s_axis_tdata   (s_axis_tdata),
    .s_axis_tvalid  (s_axis_tvalid),
    .s_axis_tready  (s_axis_tready),
    .s_axis_tlast   (s_axis_tlast),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready),
    .m_axis_tlast   (m_axis_tlast),
    .start_replay   (start_replay),
    .replay_count   (replay_count),
    .clear_capture  (clear_capture),
    .replay_busy    (replay_busy)
  );

  initial axi_aclk = 1'b0;
  always #(CLK_PERIOD / 2) axi_aclk = ~axi_aclk;

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
                            input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  // Output scoreboard, one beat per transfer
  always @(posedge axi_aclk) begin
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected output beat at %0t: data %h arrived with none expected",
                 $time, m_axis_tdata);
      end else begin
        check_data("m_axis_tdata", exp_q[0][DATA_WIDTH-1:0], m_axis_tdata);
        check_flag("m_axis_tlast", exp_q[0][DATA_WIDTH], m_axis_tlast);
        void'(exp_q.pop_front());
      end
    end
  end

  // Random back-pressure on the master stream
  always @(negedge axi_aclk) begin
    if (random_ready) begin
      m_axis_tready = 1'($random(seed));
    end
  end

  function automatic logic [DATA_WIDTH-1:0] rand_data();
    logic [DATA_WIDTH+31:0] acc;
    acc = '0;
    for (int i = 0; i < (DATA_WIDTH + 31) / 32; i++) begin
      acc = {acc[DATA_WIDTH-1:0], 32'($random(seed))};
    end
    return acc[DATA_WIDTH-1:0];
  endfunction

  // Starts and ends on a falling edge and leaves valid low
  task automatic send_beat(input logic [DATA_WIDTH-1:0] data, input logic last);
    int waited;
    waited = 0;
    s_axis_tdata  = data;
    s_axis_tlast  = last;
    s_axis_tvalid = 1'b1;
    while (!s_axis_tready && waited < MAX_WAIT) begin
      @(negedge axi_aclk);
      waited++;
    end
    if (s_axis_tready) begin
      pending.push_back({last, data});
    end else begin
      errors++;
      $display("Timeout at %0t: s_axis_tready never rose for a waiting beat", $time);
    end
    @(negedge axi_aclk);
    s_axis_tvalid = 1'b0;
  endtask

  task automatic send_packet(input int beats);
    for (int i = 0; i < beats; i++) begin
      send_beat(rand_data(), i == beats - 1);
    end
  endtask

  // Writer drains at most FIFO_DEPTH held beats, one per cycle
  task automatic settle_capture();
    repeat (FIFO_DEPTH + 2) @(negedge axi_aclk);
    while (pending.size() != 0 && captured.size() < MEM_DEPTH) begin
      captured.push_back(pending.pop_front());
    end
  endtask

  task automatic clear_store();
    clear_capture = 1'b1;
    @(negedge axi_aclk);
    clear_capture = 1'b0;
    captured.delete();
  endtask

  task automatic pulse_start(input logic [REPLAY_COUNT_WIDTH-1:0] count);
    replay_count = count;
    start_replay = 1'b1;
    @(negedge axi_aclk);
    start_replay = 1'b0;
  endtask

  task automatic queue_passes(input int count);
    for (int p = 0; p < count; p++) begin
      foreach (captured[i]) begin
        exp_q.push_back(captured[i]);
      end
    end
  endtask

  task automatic wait_replay_done();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < MAX_WAIT) begin
      @(negedge axi_aclk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout at %0t: replay did not finish, %0d beats never arrived",
               $time, exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic run_replay(input int count);
    queue_passes(count);
    pulse_start(count);
    check_flag("replay_busy", 1'b1, replay_busy);
    wait_replay_done();
    // Busy falls before the last beat can leave the egress FIFO
    check_flag("replay_busy", 1'b0, replay_busy);
  endtask

  task automatic test_basic_replay();
    send_packet(3);
    send_packet(5);
    settle_capture();
    run_replay(3);
  endtask

  task automatic test_random_ready();
    clear_store();
    send_packet(3);
    send_packet(5);
    settle_capture();
    random_ready = 1'b1;
    run_replay(3);
    random_ready  = 1'b0;
    m_axis_tready = 1'b1;
  endtask

  task automatic test_start_rules();
    pulse_start(0);
    repeat (8) begin
      check_flag("replay_busy", 1'b0, replay_busy);
      check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
      @(negedge axi_aclk);
    end
    queue_passes(2);
    pulse_start(2);
    check_flag("replay_busy", 1'b1, replay_busy);
    repeat (2) @(negedge axi_aclk);
    // Second start mid replay must not change the pass count
    pulse_start(5);
    wait_replay_done();
    repeat (8) begin
      check_flag("replay_busy", 1'b0, replay_busy);
      @(negedge axi_aclk);
    end
  endtask

  task automatic test_busy_backpressure();
    logic [DATA_WIDTH-1:0] held_data;
    int                    waited;
    waited = 0;
    queue_passes(4);
    pulse_start(4);
    check_flag("replay_busy", 1'b1, replay_busy);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      send_beat(rand_data(), 1'b0);
    end
    check_flag("replay_busy", 1'b1, replay_busy);
    check_flag("s_axis_tready", 1'b0, s_axis_tready);
    held_data     = rand_data();
    s_axis_tdata  = held_data;
    s_axis_tlast  = 1'b0;
    s_axis_tvalid = 1'b1;
    while (replay_busy && waited < MAX_WAIT) begin
      check_flag("s_axis_tready", 1'b0, s_axis_tready);
      @(negedge axi_aclk);
      waited++;
    end
    send_beat(held_data, 1'b0);
    send_beat(rand_data(), 1'b1);
    wait_replay_done();
    settle_capture();
    run_replay(1);
  endtask

  task automatic test_overflow();
    clear_store();
    for (int i = 0; i < MEM_DEPTH + FIFO_DEPTH; i++) begin
      send_beat(rand_data(), i % 8 == 7);
    end
    // One more beat must find the ingress FIFO closed
    s_axis_tdata  = rand_data();
    s_axis_tlast  = 1'b1;
    s_axis_tvalid = 1'b1;
    repeat (8) begin
      check_flag("s_axis_tready", 1'b0, s_axis_tready);
      @(negedge axi_aclk);
    end
    s_axis_tvalid = 1'b0;
    settle_capture();
    run_replay(1);
    check_flag("s_axis_tready", 1'b0, s_axis_tready);
  endtask

  task automatic test_clear();
    // Beats held since the overflow land in the emptied store first
    clear_store();
    settle_capture();
    clear_store();
    send_packet(2);
    settle_capture();
    run_replay(2);
  endtask

  initial begin
    seed          = 32'he618_e0c8;
    errors        = 0;
    random_ready  = 1'b0;
    rst           = 1'b1;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b1;
    start_replay  = 1'b0;
    replay_count  = '0;
    clear_capture = 1'b0;
    repeat (2) @(posedge axi_aclk);
    @(negedge axi_aclk);
    rst = 1'b0;
    check_flag("s_axis_tready", 1'b1, s_axis_tready);
    check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
    check_flag("replay_busy", 1'b0, replay_busy);

    test_basic_replay();
    test_random_ready();
    test_start_rules();
    test_busy_backpressure();
    test_overflow();
    test_clear();

    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Allows 20 cycles per beat of all tests
  initial begin
    #(TOTAL_BEATS * 20 * CLK_PERIOD);
    $display("Watchdog expired at %0t: the tests did not complete in time", $time);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* filelist.f */
common/replay_pkg.sv
logic/stream_fifo.sv
capture/capture_writer.sv
logic/packet_mem.sv
replay/replay_reader.sv
logic/pcap_replay_top.sv
dv/pcap_replay_asserts.sv
dv/pcap_replay_tb.sv

/* logic/packet_mem.sv */
// ==============================
// Packet store. One write port, one read port with a registered
// output, so read data appears one cycle after rd_en.
// Each word holds the beat data with the last flag on top.
// ==============================

`timescale 1ns/100ps

module packet_mem #(
  parameter int DATA_WIDTH     = 64,
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                      clk,
  input  logic                      wr_en,
  input  logic [MEM_ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH:0]       wr_word,
  input  logic                      rd_en,
  input  logic [MEM_ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH:0]       rd_word
);

  logic [DATA_WIDTH:0] words [2**MEM_ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      words[wr_addr] <= wr_word;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= words[rd_addr];
    end
  end

endmodule

/* logic/pcap_replay_top.sv */
// ==============================
// Packet capture and replay engine, top level.
// Ingress FIFO -> capture writer -> packet memory -> replay reader
// -> egress FIFO. All on axi_aclk with a synchronous rst.
// ==============================

`timescale 1ns/100ps

module pcap_replay_top #(
  parameter int DATA_WIDTH     = replay_pkg::DEFAULT_DATA_WIDTH,
  parameter int MEM_ADDR_WIDTH = replay_pkg::DEFAULT_MEM_ADDR_WIDTH
) (
  input  logic                                       axi_aclk,
  input  logic                                       rst,
  input  logic [DATA_WIDTH-1:0]                      s_axis_tdata,
  input  logic                                       s_axis_tvalid,
  output logic                                       s_axis_tready,
  input  logic                                       s_axis_tlast,
  output logic [DATA_WIDTH-1:0]                      m_axis_tdata,
  output logic                                       m_axis_tvalid,
  input  logic                                       m_axis_tready,
  output logic                                       m_axis_tlast,
  input  logic                                       start_replay,
  input  logic [replay_pkg::REPLAY_COUNT_WIDTH-1:0]  replay_count,
  input  logic                                       clear_capture,
  output logic                                       replay_busy
);

  import replay_pkg::*;

  // One stream beat, data plus last flag
  typedef struct packed {
    logic                  last;
    logic [DATA_WIDTH-1:0] data;
  } beat_t;

  beat_t                        s_beat;
  beat_t                        ing_beat;
  beat_t                        egr_beat;
  beat_t                        m_beat;
  logic                         ing_valid;
  logic                         ing_ready;
  logic                         push_valid;
  logic [$clog2(FIFO_DEPTH+1)-1:0] egr_count;
  logic                         wr_en;
  logic [MEM_ADDR_WIDTH-1:0]    wr_addr;
  logic [DATA_WIDTH:0]          wr_word;
  logic                         rd_en;
  logic [MEM_ADDR_WIDTH-1:0]    rd_addr;
  logic [DATA_WIDTH:0]          rd_word;
  logic [MEM_ADDR_WIDTH:0]      stored_count;

  assign s_beat.data   = s_axis_tdata;
  assign s_beat.last   = s_axis_tlast;
  assign m_axis_tdata  = m_beat.data;
  assign m_axis_tlast  = m_beat.last;

  // Occupancy of the ingress side is not needed
  stream_fifo #(
    .payload_t   (beat_t)
  ) ingress_fifo (
    .clk         (axi_aclk),
    .rst         (rst),
    .in_valid    (s_axis_tvalid),
    .in_ready    (s_axis_tready),
    .in_payload  (s_beat),
    .out_valid   (ing_valid),
    .out_ready   (ing_ready),
    .out_payload (ing_beat),
    .count       ()
  );

  capture_writer #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) capture_writer_inst (
    .clk            (axi_aclk),
    .rst            (rst),
    .clear_capture  (clear_capture),
    .replay_busy    (replay_busy),
    .beat_valid     (ing_valid),
    .beat_ready     (ing_ready),
    .beat_data      (ing_beat.data),
    .beat_last      (ing_beat.last),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_word        (wr_word),
    .stored_count   (stored_count)
  );

  packet_mem #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) packet_mem_inst (
    .clk            (axi_aclk),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_word        (wr_word),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_word        (rd_word)
  );

  replay_reader #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) replay_reader_inst (
    .clk            (axi_aclk),
    .rst            (rst),
    .start_replay   (start_replay),
    .replay_count   (replay_count),
    .stored_count   (stored_count),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_word        (rd_word),
    .fifo_count     (egr_count),
    .push_valid     (push_valid),
    .push_data      (egr_beat.data),
    .push_last      (egr_beat.last),
    .replay_busy    (replay_busy)
  );

  // Reader credit check guarantees room, so in_ready is left open
  stream_fifo #(
    .payload_t   (beat_t)
  ) egress_fifo (
    .clk         (axi_aclk),
    .rst         (rst),
    .in_valid    (push_valid),
    .in_ready    (),
    .in_payload  (egr_beat),
    .out_valid   (m_axis_tvalid),
    .out_ready   (m_axis_tready),
    .out_payload (m_beat),
    .count       (egr_count)
  );

endmodule

/* logic/stream_fifo.sv */
// ==============================
// Small valid/ready FIFO for one stream beat per entry.
// The payload type is a parameter. count exposes the occupancy
// so an upstream producer can run credit based flow control.
// ==============================

`timescale 1ns/100ps

module stream_fifo #(
  parameter type payload_t = logic
) (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           in_valid,
  output logic                                           in_ready,
  input  payload_t                                       in_payload,
  output logic                                           out_valid,
  input  logic                                           out_ready,
  output payload_t                                       out_payload,
  output logic [$clog2(replay_pkg::FIFO_DEPTH+1)-1:0]    count
);

  import replay_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t           entries [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic               push;
  logic               pop;

  assign in_ready    = (count != CNT_W'(FIFO_DEPTH));
  assign out_valid   = (count != '0);
  assign out_payload = entries[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Storage, no reset needed
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= in_payload;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves when exactly one side transfers
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* replay/replay_reader.sv */
// ==============================
// Replay side of the engine. On start_replay it walks the stored
// words from address 0 up, once per pass, and pushes each returned
// word into the egress FIFO. Reads are issued only when the FIFO
// has room for them, so output back-pressure never drops a beat.
// ==============================

`timescale 1ns/100ps

module replay_reader #(
  parameter int DATA_WIDTH     = 64,
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         start_replay,
  input  logic [replay_pkg::REPLAY_COUNT_WIDTH-1:0]    replay_count,
  input  logic [MEM_ADDR_WIDTH:0]                      stored_count,
  output logic                                         rd_en,
  output logic [MEM_ADDR_WIDTH-1:0]                    rd_addr,
  input  logic [DATA_WIDTH:0]                          rd_word,
  input  logic [$clog2(replay_pkg::FIFO_DEPTH+1)-1:0]  fifo_count,
  output logic                                         push_valid,
  output logic [DATA_WIDTH-1:0]                        push_data,
  output logic                                         push_last,
  output logic                                         replay_busy
);

  import replay_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  replay_state_t                 state;
  logic [MEM_ADDR_WIDTH:0]       last_addr;
  logic [REPLAY_COUNT_WIDTH-1:0] passes;
  logic [REPLAY_COUNT_WIDTH-1:0] pass_cnt;
  logic                          rd_vld;
  logic [CNT_W:0]                credit_used;
  logic                          start_ok;
  logic                          end_of_pass;

  assign start_ok = start_replay && (stored_count != '0) && (replay_count != '0);

  // FIFO entries taken plus the word returning this cycle
  assign credit_used = fifo_count + rd_vld;

  assign rd_en       = (state == READ) && (credit_used < (CNT_W + 1)'(FIFO_DEPTH));
  assign end_of_pass = ({1'b0, rd_addr} == last_addr);

  assign replay_busy = (state != IDLE);

  // Returning word goes straight into the egress FIFO
  assign push_valid = rd_vld;
  assign push_data  = rd_word[DATA_WIDTH-1:0];
  assign push_last  = rd_word[DATA_WIDTH];

  // Replay length, sampled at start
  always_ff @(posedge clk) begin
    if (state == IDLE && start_ok) begin
      last_addr <= stored_count - 1'b1;
      passes    <= replay_count;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      rd_addr  <= '0;
      pass_cnt <= '0;
      rd_vld   <= 1'b0;
    end else begin
      rd_vld <= rd_en;
      case (state)
        IDLE: begin
          if (start_ok) begin
            rd_addr  <= '0;
            pass_cnt <= '0;
            state    <= READ;
          end
        end
        READ: begin
          if (rd_en) begin
            if (end_of_pass) begin
              rd_addr <= '0;
              if (pass_cnt == passes - 1'b1) begin
                state <= DRAIN;
              end else begin
                pass_cnt <= pass_cnt + 1'b1;
              end
            end else begin
              rd_addr <= rd_addr + 1'b1;
            end
          end
        end
        DRAIN: begin
          // Last word is pushed this cycle
          if (rd_vld) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule
